//--- common/render_settings.svh
`ifndef RENDER_SETTINGS_SVH
`define RENDER_SETTINGS_SVH

// Map geometry in pixels.
`define MAP_H 320
`define MAP_V 240

// Coordinate widths.
`define MAP_H_WIDTH 9
`define MAP_V_WIDTH 8

// Any image index fits a full map.
`define INDEX_WIDTH (`MAP_H_WIDTH + `MAP_V_WIDTH)

// Square sprite sides.
`define PLAYER_SIZE 16
`define BULLET_SIZE 4

// Start caption box on screen, both bounds inclusive.
`define START_CAPTION_H_MIN 101
`define START_CAPTION_H_MAX 220
`define START_CAPTION_V_MIN 101
`define START_CAPTION_V_MAX 140

// Row length of the caption image.
`define START_CAPTION_H 120

// Hit record buffer, power of two.
`define HIT_FIFO_DEPTH 4

`endif

//--- common/render_pkg.sv
`include "render_settings.svh"

package render_pkg;

    // Object shown at a pixel, values match the image memory select.
    typedef enum logic [2:0] {
        OBJ_MAP           = 3'd0,
        OBJ_PLAYER1       = 3'd1,
        OBJ_PLAYER2       = 3'd2,
        OBJ_BULLET1       = 3'd3,
        OBJ_BULLET2       = 3'd4,
        OBJ_START_CAPTION = 3'd5,
        OBJ_START_BG      = 3'd6
    } object_id_t;

    // Everything known about one pixel before priority is applied.
    typedef struct packed {
        logic                    is_gaming;
        logic                    hit_player1;
        logic                    hit_player2;
        logic                    hit_bullet1; // Already qualified by bullet enable.
        logic                    hit_bullet2;
        logic                    hit_caption;
        logic [`INDEX_WIDTH-1:0] player1_index;
        logic [`INDEX_WIDTH-1:0] player2_index;
        logic [`INDEX_WIDTH-1:0] bullet1_index;
        logic [`INDEX_WIDTH-1:0] bullet2_index;
        logic [`INDEX_WIDTH-1:0] caption_index;
        logic [`INDEX_WIDTH-1:0] map_index;
    } hit_rec_t;

endpackage

//--- common/hit_if.sv
`timescale 1ns/10ps

// One hit record per transfer, valid/ready handshake.
interface hit_if;
    logic                 valid;
    logic                 ready;
    render_pkg::hit_rec_t rec;

    modport source (
        output valid,
        output rec,
        input  ready
    );

    modport sink (
        input  valid,
        input  rec,
        output ready
    );
endinterface

//--- source/sprite_hit_stage.sv
`timescale 1ns/10ps
`include "render_settings.svh"

module sprite_hit_stage (
    input                                  clk,
    input                                  i_reset,
    input                                  i_pix_valid,
    output logic                           o_pix_ready,
    input        [`MAP_H_WIDTH-1:0]        i_pix_h,
    input        [`MAP_V_WIDTH-1:0]        i_pix_v,
    input                                  i_is_gaming,
    input signed [`MAP_H_WIDTH-1:0]        i_player1_x,
    input signed [`MAP_V_WIDTH-1:0]        i_player1_y,
    input signed [`MAP_H_WIDTH-1:0]        i_player2_x,
    input signed [`MAP_V_WIDTH-1:0]        i_player2_y,
    input signed [`MAP_H_WIDTH-1:0]        i_bullet1_x,
    input signed [`MAP_H_WIDTH-1:0]        i_bullet1_y,
    input                                  i_bullet1_valid,
    input signed [`MAP_H_WIDTH-1:0]        i_bullet2_x,
    input signed [`MAP_H_WIDTH-1:0]        i_bullet2_y,
    input                                  i_bullet2_valid,
    hit_if.source                          o_hit
);
    localparam int SW = `MAP_H_WIDTH + 2; // Box bounds can go negative or past the map.

    // Returns {hit, index} for a square sprite of side size centred at (x, y).
    function automatic logic [`INDEX_WIDTH:0] sprite_lookup(
        input logic signed [SW-1:0]     x,
        input logic signed [SW-1:0]     y,
        input int                       size,
        input logic [`MAP_H_WIDTH-1:0]  h,
        input logic [`MAP_V_WIDTH-1:0]  v
    );
        logic signed [SW-1:0]    h_min;
        logic signed [SW-1:0]    h_max;
        logic signed [SW-1:0]    v_min;
        logic signed [SW-1:0]    v_max;
        logic signed [SW-1:0]    h_s;
        logic signed [SW-1:0]    v_s;
        logic                    hit;
        logic [`INDEX_WIDTH-1:0] index;
        h_min = x + SW'((`MAP_H - size) / 2 + 1);
        h_max = x + SW'((`MAP_H + size) / 2);
        v_min = -y + SW'((`MAP_V - size) / 2 + 1); // Screen rows grow downwards.
        v_max = -y + SW'((`MAP_V + size) / 2);
        h_s = $signed({{(SW-`MAP_H_WIDTH){1'b0}}, h});
        v_s = $signed({{(SW-`MAP_V_WIDTH){1'b0}}, v});
        hit = (h_s >= h_min) && (h_s <= h_max) && (v_s >= v_min) && (v_s <= v_max);
        index = `INDEX_WIDTH'((v_s - v_min) * size + (h_s - h_min)); // Only used on a hit.
        return {hit, index};
    endfunction

    logic                    p1_hit, p2_hit, b1_box_hit, b2_box_hit;
    logic [`INDEX_WIDTH-1:0] p1_index, p2_index, b1_index, b2_index;
    logic                    caption_hit;
    logic [`INDEX_WIDTH-1:0] caption_index;
    logic [`INDEX_WIDTH-1:0] map_index;
    render_pkg::hit_rec_t    rec_d;
    render_pkg::hit_rec_t    rec_q;
    logic                    valid_q;

    assign {p1_hit, p1_index} = sprite_lookup(i_player1_x, i_player1_y, `PLAYER_SIZE,
                                              i_pix_h, i_pix_v);
    assign {p2_hit, p2_index} = sprite_lookup(i_player2_x, i_player2_y, `PLAYER_SIZE,
                                              i_pix_h, i_pix_v);
    assign {b1_box_hit, b1_index} = sprite_lookup(i_bullet1_x, i_bullet1_y, `BULLET_SIZE,
                                                  i_pix_h, i_pix_v);
    assign {b2_box_hit, b2_index} = sprite_lookup(i_bullet2_x, i_bullet2_y, `BULLET_SIZE,
                                                  i_pix_h, i_pix_v);

    // Fixed caption box.
    assign caption_hit = (i_pix_h >= `START_CAPTION_H_MIN) && (i_pix_h <= `START_CAPTION_H_MAX)
                      && (i_pix_v >= `START_CAPTION_V_MIN) && (i_pix_v <= `START_CAPTION_V_MAX);
    assign caption_index = (i_pix_v - `START_CAPTION_V_MIN) * `START_CAPTION_H
                         + i_pix_h - `START_CAPTION_H_MIN;

    assign map_index = (i_pix_v - 1) * `MAP_H + i_pix_h - 1; // Coordinates are 1-based.

    always_comb begin
        rec_d.is_gaming     = i_is_gaming;
        rec_d.hit_player1   = p1_hit;
        rec_d.hit_player2   = p2_hit;
        rec_d.hit_bullet1   = b1_box_hit && i_bullet1_valid;
        rec_d.hit_bullet2   = b2_box_hit && i_bullet2_valid;
        rec_d.hit_caption   = caption_hit;
        rec_d.player1_index = p1_index;
        rec_d.player2_index = p2_index;
        rec_d.bullet1_index = b1_index;
        rec_d.bullet2_index = b2_index;
        rec_d.caption_index = caption_index;
        rec_d.map_index     = map_index;
    end

    // Register is free when empty or drained this cycle.
    assign o_pix_ready = !valid_q || o_hit.ready;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            valid_q <= 1'b0;
        end else if (o_pix_ready) begin
            valid_q <= i_pix_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_pix_valid && o_pix_ready) begin
            rec_q <= rec_d;
        end
    end

    assign o_hit.valid = valid_q;
    assign o_hit.rec   = rec_q;
endmodule

//--- source/hit_fifo.sv
`timescale 1ns/10ps
`include "render_settings.svh"

module hit_fifo #(
    parameter int DEPTH = `HIT_FIFO_DEPTH // Power of two.
) (
    input       clk,
    input       i_reset,
    hit_if.sink   i_wr,
    hit_if.source o_rd
);
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    render_pkg::hit_rec_t mem [DEPTH];
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [CNT_W-1:0]     count;
    logic                 wr_en;
    logic                 rd_en;

    assign i_wr.ready = (count != CNT_W'(DEPTH));
    assign o_rd.valid = (count != '0);
    assign o_rd.rec   = mem[rd_ptr]; // Head entry, registered storage only.

    assign wr_en = i_wr.valid && i_wr.ready;
    assign rd_en = o_rd.valid && o_rd.ready;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= i_wr.rec;
        end
    end

    // Pointers wrap on their own.
    always_ff @(posedge clk) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            count <= '0;
        end else begin
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // Both or neither.
            endcase
        end
    end
endmodule

//--- source/priority_resolver.sv
`timescale 1ns/10ps
`include "render_settings.svh"

module priority_resolver (
    input                                 clk,
    input                                 i_reset,
    hit_if.sink                           i_hit,
    output logic                          o_obj_valid,
    input                                 i_obj_ready,
    output render_pkg::object_id_t        o_object_id,
    output logic [`INDEX_WIDTH-1:0]       o_object_pixel_index
);
    render_pkg::hit_rec_t    rec;
    render_pkg::object_id_t  sel_id;
    logic [`INDEX_WIDTH-1:0] sel_index;
    logic                    take;

    assign rec = i_hit.rec;

    // Gaming picks player1 > player2 > bullet1 > bullet2 > map.
    always_comb begin
        if (rec.is_gaming) begin
            if (rec.hit_player1) begin
                sel_id    = render_pkg::OBJ_PLAYER1;
                sel_index = rec.player1_index;
            end else if (rec.hit_player2) begin
                sel_id    = render_pkg::OBJ_PLAYER2;
                sel_index = rec.player2_index;
            end else if (rec.hit_bullet1) begin
                sel_id    = render_pkg::OBJ_BULLET1;
                sel_index = rec.bullet1_index;
            end else if (rec.hit_bullet2) begin
                sel_id    = render_pkg::OBJ_BULLET2;
                sel_index = rec.bullet2_index;
            end else begin
                sel_id    = render_pkg::OBJ_MAP;
                sel_index = rec.map_index;
            end
        end else begin
            // Idle screen, sprites are hidden.
            if (rec.hit_caption) begin
                sel_id    = render_pkg::OBJ_START_CAPTION;
                sel_index = rec.caption_index;
            end else begin
                sel_id    = render_pkg::OBJ_START_BG;
                sel_index = rec.map_index;
            end
        end
    end

    assign i_hit.ready = !o_obj_valid || i_obj_ready;
    assign take        = i_hit.valid && i_hit.ready;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_obj_valid <= 1'b0;
        end else if (i_hit.ready) begin
            o_obj_valid <= i_hit.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            o_object_id          <= sel_id;
            o_object_pixel_index <= sel_index;
        end
    end
endmodule

//--- source/pixel_decoder_top.sv
`timescale 1ns/10ps
`include "render_settings.svh"

module pixel_decoder_top (
    input                                  clk,
    input                                  i_reset,

    // Pixel stream in.
    input                                  i_pix_valid,
    output                                 o_pix_ready,
    input        [`MAP_H_WIDTH-1:0]        i_pix_h,
    input        [`MAP_V_WIDTH-1:0]        i_pix_v,

    // Game state held with each pixel.
    input                                  i_is_gaming,
    input signed [`MAP_H_WIDTH-1:0]        i_player1_x,
    input signed [`MAP_V_WIDTH-1:0]        i_player1_y,
    input signed [`MAP_H_WIDTH-1:0]        i_player2_x,
    input signed [`MAP_V_WIDTH-1:0]        i_player2_y,
    input signed [`MAP_H_WIDTH-1:0]        i_bullet1_x,
    input signed [`MAP_H_WIDTH-1:0]        i_bullet1_y,
    input                                  i_bullet1_valid,
    input signed [`MAP_H_WIDTH-1:0]        i_bullet2_x,
    input signed [`MAP_H_WIDTH-1:0]        i_bullet2_y,
    input                                  i_bullet2_valid,

    // Decoded object stream out.
    output                                 o_obj_valid,
    input                                  i_obj_ready,
    output render_pkg::object_id_t         o_object_id,
    output       [`INDEX_WIDTH-1:0]        o_object_pixel_index
);
    hit_if prod_to_buf ();
    hit_if buf_to_cons ();

    sprite_hit_stage u_sprite_hit_stage (
        .clk             (clk),
        .i_reset         (i_reset),
        .i_pix_valid     (i_pix_valid),
        .o_pix_ready     (o_pix_ready),
        .i_pix_h         (i_pix_h),
        .i_pix_v         (i_pix_v),
        .i_is_gaming     (i_is_gaming),
        .i_player1_x     (i_player1_x),
        .i_player1_y     (i_player1_y),
        .i_player2_x     (i_player2_x),
        .i_player2_y     (i_player2_y),
        .i_bullet1_x     (i_bullet1_x),
        .i_bullet1_y     (i_bullet1_y),
        .i_bullet1_valid (i_bullet1_valid),
        .i_bullet2_x     (i_bullet2_x),
        .i_bullet2_y     (i_bullet2_y),
        .i_bullet2_valid (i_bullet2_valid),
        .o_hit           (prod_to_buf)
    );

    hit_fifo #(
        .DEPTH (`HIT_FIFO_DEPTH)
    ) u_hit_fifo (
        .clk     (clk),
        .i_reset (i_reset),
        .i_wr    (prod_to_buf),
        .o_rd    (buf_to_cons)
    );

    priority_resolver u_priority_resolver (
        .clk                  (clk),
        .i_reset              (i_reset),
        .i_hit                (buf_to_cons),
        .o_obj_valid          (o_obj_valid),
        .i_obj_ready          (i_obj_ready),
        .o_object_id          (o_object_id),
        .o_object_pixel_index (o_object_pixel_index)
    );
endmodule

//--- verif/tb_pixel_decoder.sv
`timescale 1ns/10ps
`include "render_settings.svh"

module tb_pixel_decoder;
    localparam int HW = `MAP_H_WIDTH;
    localparam int VW = `MAP_V_WIDTH;
    localparam int MAX_PIX = 64;
    localparam int WAIT_LIMIT = 200;   // Cycles a pixel may wait for o_pix_ready.
    localparam int DRAIN_LIMIT = 2000;
    localparam int MODE_FREE = 0;
    localparam int MODE_HOLD = 1;
    localparam int MODE_LONG = 2;
    localparam int MODE_RAND = 3;

    logic                   clk = 1'b0;
    logic                   i_reset;
    logic                   i_pix_valid;
    logic                   o_pix_ready;
    logic [HW-1:0]          i_pix_h;
    logic [VW-1:0]          i_pix_v;
    logic                   i_is_gaming;
    logic signed [HW-1:0]   i_player1_x;
    logic signed [VW-1:0]   i_player1_y;
    logic signed [HW-1:0]   i_player2_x;
    logic signed [VW-1:0]   i_player2_y;
    logic signed [HW-1:0]   i_bullet1_x;
    logic signed [HW-1:0]   i_bullet1_y;
    logic                   i_bullet1_valid;
    logic signed [HW-1:0]   i_bullet2_x;
    logic signed [HW-1:0]   i_bullet2_y;
    logic                   i_bullet2_valid;
    logic                   o_obj_valid;
    logic                   i_obj_ready = 1'b1;
    render_pkg::object_id_t o_object_id;
    logic [`INDEX_WIDTH-1:0] o_object_pixel_index;

    int          pat [MAX_PIX][15]; // One row per pattern line, columns as in the file.
    int          num_pix = 0;
    int          exp_id_q [$];
    int          exp_idx_q [$];
    int          exp_num_q [$];
    int          error_count = 0;
    int          timeout_count = 0;
    int          ready_mode = MODE_FREE;
    int          stall_cnt = 0;
    logic [15:0] rand_state = 16'd6;
    bit          ok;

    always #4 clk = ~clk;

    pixel_decoder_top DUT (.*);

    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR: %s = 0x%0h, expected 0x%0h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic load_patterns;
        int    fd;
        int    code;
        string line;
        int    f [15];
        fd = $fopen("verif/pixel_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open the pattern file verif/pixel_patterns.txt");
            error_count++;
            return;
        end
        while (!$feof(fd) && num_pix < MAX_PIX) begin
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 0 && line[0] != "#") begin
                code = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                               f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                               f[8], f[9], f[10], f[11], f[12], f[13], f[14]);
                if (code == 15) begin
                    pat[num_pix] = f;
                    num_pix++;
                end else if (code > 0) begin
                    $display("Pattern line after entry %0d has too few columns", num_pix);
                    error_count++;
                end
            end
        end
        $fclose(fd);
        if (num_pix == 0) begin
            $display("The pattern file holds no pixels");
            error_count++;
        end
    endtask

    // Holds the pixel until it is taken or the limit runs out.
    task automatic send_pixel(input int k, input int limit, output bit accepted);
        int waited;
        waited = 0;
        accepted = 1'b0;
        @(negedge clk);
        i_is_gaming     = pat[k][0] != 0;
        i_player1_x     = HW'(pat[k][1]);
        i_player1_y     = VW'(pat[k][2]);
        i_player2_x     = HW'(pat[k][3]);
        i_player2_y     = VW'(pat[k][4]);
        i_bullet1_x     = HW'(pat[k][5]);
        i_bullet1_y     = HW'(pat[k][6]);
        i_bullet1_valid = pat[k][7] != 0;
        i_bullet2_x     = HW'(pat[k][8]);
        i_bullet2_y     = HW'(pat[k][9]);
        i_bullet2_valid = pat[k][10] != 0;
        i_pix_h         = HW'(pat[k][11]);
        i_pix_v         = VW'(pat[k][12]);
        i_pix_valid     = 1'b1;
        while (!accepted && waited < limit) begin
            if (o_pix_ready === 1'b1) begin
                accepted = 1'b1; // Transfer on the coming rising edge.
                exp_id_q.push_back(pat[k][13]);
                exp_idx_q.push_back(pat[k][14]);
                exp_num_q.push_back(k);
            end else begin
                @(negedge clk);
                waited++;
            end
        end
    endtask

    task automatic send_range(input int first, input int last);
        bit taken;
        for (int k = first; k <= last; k++) begin
            send_pixel(k, WAIT_LIMIT, taken);
            if (!taken) begin
                $display("Timeout: pixel %0d not accepted within %0d cycles", k, WAIT_LIMIT);
                timeout_count++;
            end
        end
    endtask

    task automatic drain;
        int waited;
        waited = 0;
        @(negedge clk);
        i_pix_valid = 1'b0;
        while (exp_id_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_id_q.size() != 0) begin
            $display("Timeout: %0d results missing after %0d cycles", exp_id_q.size(), waited);
            timeout_count++;
            exp_id_q.delete();
            exp_idx_q.delete();
            exp_num_q.delete();
        end
    endtask

    task automatic set_mode(input int mode);
        @(posedge clk);
        ready_mode = mode;
    endtask

    // Output side works on the falling edge, where the registered outputs are settled.
    always @(negedge clk) begin
        int num;
        case (ready_mode)
            MODE_HOLD: i_obj_ready = 1'b0;
            MODE_LONG: begin
                i_obj_ready = (stall_cnt % 26) >= 20; // Low 20 cycles, high 6.
                stall_cnt++;
            end
            MODE_RAND: begin
                rand_state = lfsr_step(rand_state);
                i_obj_ready = rand_state[0];
            end
            default: i_obj_ready = 1'b1;
        endcase
        if (i_reset) begin
            check_value("o_obj_valid", o_obj_valid, 0);
        end else if (o_obj_valid === 1'b1 && i_obj_ready) begin
            if (exp_id_q.size() == 0) begin
                $display("A result came out with no pixel outstanding");
                error_count++;
            end else begin
                num = exp_num_q.pop_front();
                check_value($sformatf("o_object_id (pixel %0d)", num), o_object_id,
                            exp_id_q.pop_front());
                check_value($sformatf("o_object_pixel_index (pixel %0d)", num),
                            o_object_pixel_index, exp_idx_q.pop_front());
            end
        end
    end

    initial begin
        i_reset = 1'b1;
        i_pix_valid = 1'b0;
        i_pix_h = '0;
        i_pix_v = '0;
        i_is_gaming = 1'b0;
        i_player1_x = '0;
        i_player1_y = '0;
        i_player2_x = '0;
        i_player2_y = '0;
        i_bullet1_x = '0;
        i_bullet1_y = '0;
        i_bullet1_valid = 1'b0;
        i_bullet2_x = '0;
        i_bullet2_y = '0;
        i_bullet2_valid = 1'b0;
        load_patterns();
        repeat (4) @(negedge clk);
        i_reset = 1'b0;
        @(negedge clk);
        check_value("o_obj_valid", o_obj_valid, 0);
        check_value("o_pix_ready", o_pix_ready, 1);

        send_range(0, num_pix - 1); // Output always ready.
        drain();

        // Six pixels fill producer, FIFO and resolver against a held output.
        if (num_pix > 6) begin
            set_mode(MODE_HOLD);
            send_range(0, 5);
            send_pixel(6, 12, ok);
            if (ok) begin
                $display("o_pix_ready stayed high with six pixels waiting");
                error_count++;
            end
            set_mode(MODE_LONG);
            send_range(6, num_pix - 1);
            drain();
        end

        set_mode(MODE_RAND);
        send_range(0, num_pix - 1);
        drain();
        repeat (8) @(posedge clk);

        $display("Checks done: %0d errors, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end
endmodule

//--- pixel_decoder.f
+incdir+common
common/render_pkg.sv
common/hit_if.sv
source/sprite_hit_stage.sv
source/hit_fifo.sv
source/priority_resolver.sv
source/pixel_decoder_top.sv
verif/tb_pixel_decoder.sv

//--- Makefile
# Verilator flow for the pixel decoder testbench.
VERILATOR ?= verilator
TOP       ?= tb_pixel_decoder
FILELIST  ?= pixel_decoder.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= *** TEST PASSED ***
VFLAGS    ?= --binary --timing -Wno-fatal

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "Simulation result: pass"; \
	else \
		echo "Simulation result: fail, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verif/pixel_patterns.txt
# Columns: gaming p1_x p1_y p2_x p2_y b1_x b1_y b1_valid b2_x b2_y b2_valid h v
#          expected_object_id expected_index (decimal, centre coordinates signed)
1 0 0 100 0 0 0 0 0 0 0 1 1 0 0
1 0 0 100 0 0 0 0 0 0 0 320 240 0 76799
1 0 0 100 0 0 0 0 0 0 0 50 30 0 9329
1 -20 15 100 0 0 0 0 0 0 0 133 98 1 0
1 -20 15 100 0 0 0 0 0 0 0 148 113 1 255
1 -20 15 100 0 0 0 0 0 0 0 140 105 1 119
1 -20 15 100 0 0 0 0 0 0 0 132 98 0 31171
1 -20 15 100 0 0 0 0 0 0 0 149 113 0 35988
1 -20 15 100 0 0 0 0 0 0 0 140 97 0 30859
1 -20 15 100 0 0 0 0 0 0 0 140 114 0 36299
1 -20 15 -60 -30 0 0 0 0 0 0 93 143 2 0
1 -20 15 -60 -30 0 0 0 0 0 0 108 158 2 255
1 -20 15 -60 -30 0 0 0 0 0 0 100 150 2 119
1 -20 15 -60 -30 0 0 0 0 0 0 92 150 0 47771
1 -20 15 -60 -30 0 0 0 0 0 0 100 159 0 50659
1 -20 15 -60 -30 30 -50 1 0 0 0 189 169 3 0
1 -20 15 -60 -30 30 -50 1 0 0 0 192 172 3 15
1 -20 15 -60 -30 30 -50 1 0 0 0 190 171 3 9
1 -20 15 -60 -30 30 -50 1 0 0 0 193 170 0 54272
1 -20 15 -60 -30 30 -50 1 -100 60 1 61 60 4 6
1 -20 15 -60 -30 30 -50 1 -100 60 1 62 62 4 15
1 -20 15 -60 -30 30 -50 1 -100 60 1 61 58 0 18300
1 0 0 0 0 0 0 1 0 0 1 160 120 1 119
1 -100 0 0 0 0 0 1 0 0 1 160 120 2 119
1 -100 0 100 0 0 0 1 0 0 1 160 120 3 5
1 -100 0 100 0 0 0 0 0 0 1 160 120 4 5
1 -100 0 100 0 0 0 0 0 0 0 160 120 0 38239
1 -100 0 0 0 0 0 1 0 0 0 159 119 2 102
0 0 0 100 0 0 0 1 0 0 1 101 101 5 0
0 0 0 100 0 0 0 1 0 0 1 220 140 5 4799
0 0 0 100 0 0 0 1 0 0 1 160 120 5 2339
0 0 0 100 0 0 0 1 0 0 1 100 101 6 32099
0 0 0 100 0 0 0 1 0 0 1 221 140 6 44700
0 0 0 100 0 0 0 1 0 0 1 160 141 6 44959
0 0 0 100 0 0 0 1 0 0 1 260 120 6 38339
0 0 0 100 0 0 0 1 0 0 1 1 1 6 0
0 0 0 100 0 0 0 1 0 0 1 101 100 6 31780
